// ==== Makefile ====
# Verilator build and run of the I/O port controller testbench.
# Override any variable on the command line, e.g. make sim BUILD_DIR=build

VERILATOR ?= verilator
TOP       ?= io_port_controller_tb
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
SIM_BIN   ?= sim_$(TOP)
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

# the simulator exits nonzero on any failed check, timeout or assertion
sim:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(BUILD_DIR) -o $(SIM_BIN)
	./$(BUILD_DIR)/$(SIM_BIN)

clean:
	rm -rf $(BUILD_DIR)

// ==== flist.f ====
+incdir+rtl
rtl/io_bus_pkg.sv
rtl/io_periph_pkg.sv
rtl/io_decoder.sv
rtl/timer_channel.sv
rtl/irq_controller.sv
rtl/io_readback.sv
rtl/io_port_controller.sv
tests/io_port_controller_sva.sv
tests/io_port_controller_tb.sv

// ==== rtl/io_bus_pkg.sv ====
`default_nettype none

`include "io_defines.svh"

package io_bus_pkg;

	typedef logic [`IO_PAGE_BITS-1:0] io_page_t;

	// one cpu bus cycle as seen by the port controller
	typedef struct packed {
		logic [`IO_ADDR_BITS-1:0] addr;
		logic [`IO_DATA_BITS-1:0] wdata;
		logic                     wr;   // write strobe
		logic                     rd;   // read request
	} io_req_t;

	// registered read select, one cycle behind the address
	typedef struct packed {
		io_page_t page;
		logic     hit;  // page is mapped
	} io_rsel_t;

	function automatic io_page_t page_of(input logic [`IO_ADDR_BITS-1:0] addr);
		return addr[`IO_ADDR_BITS-1 -: `IO_PAGE_BITS];
	endfunction

endpackage

`default_nettype wire

// ==== rtl/io_decoder.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "io_defines.svh"

module io_decoder (
	input  logic                      CLK,
	input  logic                      RSTb,
	input  io_bus_pkg::io_req_t       req,
	output logic [`IO_NUM_TIMERS-1:0] timer_wr,
	output logic                      irq_wr,
	output io_bus_pkg::io_rsel_t      rsel
);

	import io_bus_pkg::*;

	io_page_t page;
	logic     hit;

	// memory map
	//   page 0 .. NUM_TIMERS-1 : timer channels
	//   page IO_IRQ_PAGE       : interrupt controller
	//   anything else          : reads zero, writes dropped
	always_comb begin
		page     = page_of(req.addr);
		timer_wr = '0;
		irq_wr   = 1'b0;
		hit      = 1'b0;

		for (int i = 0; i < `IO_NUM_TIMERS; i++) begin
			if (page == io_page_t'(i)) begin
				timer_wr[i] = req.wr;
				hit         = 1'b1;
			end
		end

		if (page == io_page_t'(`IO_IRQ_PAGE)) begin
			irq_wr = req.wr;
			hit    = 1'b1;
		end
	end

	// page and hit follow the read word into the next cycle
	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			rsel <= '0;
		end else begin
			rsel.page <= page;
			rsel.hit  <= hit;
		end
	end

endmodule

`default_nettype wire

// ==== rtl/io_defines.svh ====
`ifndef IO_DEFINES_SVH
`define IO_DEFINES_SVH

// cpu bus widths
`define IO_DATA_BITS 16
`define IO_ADDR_BITS 16

// top nibble of the address selects a 4 KB page
`define IO_PAGE_BITS 4

// register offset inside a page, low address bits
`define IO_REG_BITS 4

// timers sit on pages 0 .. IO_NUM_TIMERS-1
`define IO_NUM_TIMERS 4
`define IO_IRQ_PAGE 7

`endif

// ==== rtl/io_periph_pkg.sv ====
`default_nettype none

`include "io_defines.svh"

package io_periph_pkg;

	// timer control word, only the two low bits are defined
	typedef struct packed {
		logic [`IO_DATA_BITS-3:0] rsvd;         // reads zero
		logic                     reload_mode;  // 1 reload, 0 one-shot
		logic                     enable;
	} timer_ctrl_t;

	// offsets within a timer page
	typedef enum logic [`IO_REG_BITS-1:0] {
		CTRL   = 4'd0,
		RELOAD = 4'd1,
		COUNT  = 4'd2   // read only
	} timer_reg_e;

	// offsets within the interrupt page
	typedef enum logic [`IO_REG_BITS-1:0] {
		PENDING = 4'd0,  // write 1 to clear
		MASK    = 4'd1
	} irq_reg_e;

	// one wrap pulse per timer channel
	typedef logic [`IO_NUM_TIMERS-1:0] timer_evt_t;

endpackage

`default_nettype wire

// ==== rtl/io_port_controller.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "io_defines.svh"

module io_port_controller (
	input  logic                     CLK,
	input  logic                     RSTb,
	input  logic [`IO_ADDR_BITS-1:0] address,
	input  logic [`IO_DATA_BITS-1:0] data_in,
	input  logic                     mem_wr,
	input  logic                     mem_rd,
	output logic [`IO_DATA_BITS-1:0] data_out,
	output logic                     interrupt
);

	import io_bus_pkg::*;
	import io_periph_pkg::*;

	io_req_t                   req;
	io_rsel_t                  rsel;
	logic [`IO_NUM_TIMERS-1:0] timer_wr;
	logic                      irq_wr;
	logic [`IO_DATA_BITS-1:0]  timer_rdata [`IO_NUM_TIMERS];
	logic [`IO_DATA_BITS-1:0]  irq_rdata;
	timer_evt_t                timer_evt;

	assign req = '{addr: address, wdata: data_in, wr: mem_wr, rd: mem_rd};

	io_decoder u_decoder (
		.CLK      (CLK),
		.RSTb     (RSTb),
		.req      (req),
		.timer_wr (timer_wr),
		.irq_wr   (irq_wr),
		.rsel     (rsel)
	);

	for (genvar i = 0; i < `IO_NUM_TIMERS; i++) begin : g_timer
		timer_channel u_timer (
			.CLK   (CLK),
			.RSTb  (RSTb),
			.req   (req),
			.wr    (timer_wr[i]),
			.rdata (timer_rdata[i]),
			.evt   (timer_evt[i])
		);
	end

	irq_controller u_irq (
		.CLK       (CLK),
		.RSTb      (RSTb),
		.req       (req),
		.wr        (irq_wr),
		.evt       (timer_evt),
		.rdata     (irq_rdata),
		.interrupt (interrupt)
	);

	io_readback u_readback (
		.CLK         (CLK),
		.RSTb        (RSTb),
		.req         (req),
		.rsel        (rsel),
		.timer_rdata (timer_rdata),
		.irq_rdata   (irq_rdata),
		.data_out    (data_out)
	);

endmodule

`default_nettype wire

// ==== rtl/io_readback.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "io_defines.svh"

module io_readback (
	input  logic                     CLK,
	input  logic                     RSTb,
	input  io_bus_pkg::io_req_t      req,
	input  io_bus_pkg::io_rsel_t     rsel,
	input  logic [`IO_DATA_BITS-1:0] timer_rdata [`IO_NUM_TIMERS],
	input  logic [`IO_DATA_BITS-1:0] irq_rdata,
	output logic [`IO_DATA_BITS-1:0] data_out
);

	import io_bus_pkg::*;

	io_page_t                 page;
	logic [`IO_DATA_BITS-1:0] word;
	logic [`IO_DATA_BITS-1:0] hold_q;

	// non-timer pages take the irq word; rsel.hit drops the unmapped ones later
	always_comb begin
		page = page_of(req.addr);
		word = irq_rdata;
		for (int i = 0; i < `IO_NUM_TIMERS; i++) begin
			if (page == io_page_t'(i))
				word = timer_rdata[i];
		end
	end

	always_ff @(posedge CLK) begin
		if (!RSTb)
			hold_q <= '0;
		else
			hold_q <= word;  // sampled every cycle, rd or not
	end

	assign data_out = rsel.hit ? hold_q : '0;

endmodule

`default_nettype wire

// ==== rtl/irq_controller.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "io_defines.svh"

module irq_controller (
	input  logic                      CLK,
	input  logic                      RSTb,
	input  io_bus_pkg::io_req_t       req,
	input  logic                      wr,
	input  io_periph_pkg::timer_evt_t evt,
	output logic [`IO_DATA_BITS-1:0]  rdata,
	output logic                      interrupt
);

	import io_periph_pkg::*;

	timer_evt_t              pending_q;
	timer_evt_t              mask_q;
	timer_evt_t              clr;
	logic [`IO_REG_BITS-1:0] offs;
	logic                    wr_pending;
	logic                    wr_mask;

	assign offs       = req.addr[`IO_REG_BITS-1:0];
	assign wr_pending = wr && (offs == PENDING);
	assign wr_mask    = wr && (offs == MASK);

	// write 1 to clear
	assign clr = wr_pending ? req.wdata[`IO_NUM_TIMERS-1:0] : '0;

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			pending_q <= '0;
			mask_q    <= '0;
			interrupt <= 1'b0;
		end else begin
			pending_q <= (pending_q & ~clr) | evt;  // new event beats the clear
			if (wr_mask)
				mask_q <= req.wdata[`IO_NUM_TIMERS-1:0];

			// one cycle behind pending
			interrupt <= |(pending_q & mask_q);
		end
	end

	always_comb begin
		case (offs)
			PENDING: rdata = `IO_DATA_BITS'(pending_q);
			MASK:    rdata = `IO_DATA_BITS'(mask_q);
			default: rdata = '0;
		endcase
	end

endmodule

`default_nettype wire

// ==== rtl/timer_channel.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "io_defines.svh"

module timer_channel (
	input  logic                     CLK,
	input  logic                     RSTb,
	input  io_bus_pkg::io_req_t      req,
	input  logic                     wr,
	output logic [`IO_DATA_BITS-1:0] rdata,
	output logic                     evt
);

	import io_periph_pkg::*;

	timer_ctrl_t              ctrl_q;
	timer_ctrl_t              ctrl_wr;
	logic [`IO_DATA_BITS-1:0] reload_q;
	logic [`IO_DATA_BITS-1:0] count_q;
	logic [`IO_REG_BITS-1:0]  offs;
	logic                     wr_ctrl;
	logic                     wr_reload;
	logic                     running;
	logic                     wrap;

	assign offs      = req.addr[`IO_REG_BITS-1:0];
	assign wr_ctrl   = wr && (offs == CTRL);
	assign wr_reload = wr && (offs == RELOAD);

	assign running = ctrl_q.enable && (count_q != '0);
	assign wrap    = running && (count_q == `IO_DATA_BITS'(1)); // last step to zero

	always_comb begin
		ctrl_wr      = req.wdata;
		ctrl_wr.rsvd = '0;  // undefined bits never stored
	end

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			ctrl_q   <= '0;
			reload_q <= '0;
			count_q  <= '0;
			evt      <= 1'b0;
		end else begin
			evt <= wrap && !wr_reload;  // a reload write cancels the wrap

			// one-shot drops enable when it reaches zero
			if (wr_ctrl)
				ctrl_q <= ctrl_wr;
			else if (ctrl_q.enable && !ctrl_q.reload_mode && (wrap || count_q == '0))
				ctrl_q.enable <= 1'b0;

			if (wr_reload) begin
				reload_q <= req.wdata;
				count_q  <= req.wdata;
			end else if (running) begin
				count_q <= count_q - 1'b1;
			end else if (ctrl_q.enable && ctrl_q.reload_mode) begin
				count_q <= reload_q;  // sitting at zero, start over
			end
		end
	end

	always_comb begin
		case (offs)
			CTRL:    rdata = ctrl_q;
			RELOAD:  rdata = reload_q;
			COUNT:   rdata = count_q;
			default: rdata = '0;
		endcase
	end

endmodule

`default_nettype wire

// ==== tests/io_port_controller_sva.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "io_defines.svh"

module io_port_controller_sva (
	input logic                      CLK,
	input logic                      RSTb,
	input logic [`IO_DATA_BITS-1:0]  data_out,
	input logic                      interrupt,
	input logic [`IO_NUM_TIMERS-1:0] timer_wr,
	input io_periph_pkg::timer_evt_t pending,
	input io_periph_pkg::timer_evt_t mask
);

	import io_periph_pkg::*;

	timer_evt_t armed;

	assign armed = pending & mask;  // pending bits allowed to interrupt

	// outputs are quiet through reset and the cycle after
	a_reset_quiet: assert property (@(posedge CLK)
		!RSTb |=> (interrupt == 1'b0 && data_out == '0))
		else $error("interrupt or data_out not zero around reset");

	a_one_timer_wr: assert property (@(posedge CLK) disable iff (!RSTb)
		$onehot0(timer_wr))
		else $error("more than one timer page strobed in a cycle");

	// interrupt is registered from the masked pending bits
	a_irq_source: assert property (@(posedge CLK) disable iff (!RSTb)
		interrupt |-> $past(|armed))
		else $error("interrupt high without a masked pending bit");

endmodule

bind io_port_controller io_port_controller_sva u_sva (
	.CLK       (CLK),
	.RSTb      (RSTb),
	.data_out  (data_out),
	.interrupt (interrupt),
	.timer_wr  (timer_wr),
	.pending   (u_irq.pending_q),
	.mask      (u_irq.mask_q)
);

`default_nettype wire

// ==== tests/io_port_controller_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "io_defines.svh"

module io_port_controller_tb;

	import io_periph_pkg::*;

	localparam int TIMEOUT_CYCLES = 4000;  // generous bound on the full run

	logic                     CLK;
	logic                     RSTb;
	logic [`IO_ADDR_BITS-1:0] address;
	logic [`IO_DATA_BITS-1:0] data_in;
	logic                     mem_wr;
	logic                     mem_rd;
	logic [`IO_DATA_BITS-1:0] data_out;
	logic                     interrupt;

	// register model of the whole map
	logic [`IO_DATA_BITS-1:0] m_ctrl [`IO_NUM_TIMERS];
	logic [`IO_DATA_BITS-1:0] m_reload [`IO_NUM_TIMERS];
	logic [`IO_DATA_BITS-1:0] m_count [`IO_NUM_TIMERS];
	timer_evt_t               m_pending;
	timer_evt_t               m_mask;

	// queued compares
	string                    name_q [$];
	logic [`IO_DATA_BITS-1:0] exp_q [$];
	logic [`IO_DATA_BITS-1:0] act_q [$];
	int                       cycles;

	io_port_controller DUT (
		.CLK       (CLK),
		.RSTb      (RSTb),
		.address   (address),
		.data_in   (data_in),
		.mem_wr    (mem_wr),
		.mem_rd    (mem_rd),
		.data_out  (data_out),
		.interrupt (interrupt)
	);

	always #4 CLK = ~CLK;

	always @(posedge CLK) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("Checks failed");
			$fatal(1, "run did not finish within %0d cycles", TIMEOUT_CYCLES);
		end
	end

	// middle address bits are don't care, so fill them at random
	function automatic logic [`IO_ADDR_BITS-1:0] addr_of(input int page, input logic [3:0] off);
		logic [7:0] mid;
		mid = 8'($urandom);
		return {4'(page), mid, off};
	endfunction

	function automatic logic [`IO_DATA_BITS-1:0] ref_read(input int page, input logic [3:0] off);
		if (page < `IO_NUM_TIMERS) begin
			case (off)
				CTRL:    return m_ctrl[page];
				RELOAD:  return m_reload[page];
				COUNT:   return m_count[page];
				default: return '0;
			endcase
		end else if (page == `IO_IRQ_PAGE) begin
			case (off)
				PENDING: return `IO_DATA_BITS'(m_pending);
				MASK:    return `IO_DATA_BITS'(m_mask);
				default: return '0;
			endcase
		end
		return '0;  // unmapped page
	endfunction

	function automatic void model_write(input int page, input logic [3:0] off,
			input logic [`IO_DATA_BITS-1:0] data);
		if (page < `IO_NUM_TIMERS) begin
			if (off == CTRL) begin
				m_ctrl[page] = data & 16'h0003;  // enable and reload_mode only
			end else if (off == RELOAD) begin
				m_reload[page] = data;
				m_count[page]  = data;
			end
		end else if (page == `IO_IRQ_PAGE) begin
			if (off == PENDING)
				m_pending = m_pending & ~data[`IO_NUM_TIMERS-1:0];
			else if (off == MASK)
				m_mask = data[`IO_NUM_TIMERS-1:0];
		end
	endfunction

	task automatic check(input string name, input logic [15:0] expected,
			input logic [15:0] actual);
		if (actual !== expected) begin
			$display("ERROR %s: expected %h actual %h", name, expected, actual);
			$display("Checks failed");
			$fatal(1, "value mismatch in %s", name);
		end
	endtask

	task automatic expect_val(input string name, input logic [15:0] expected,
			input logic [15:0] actual);
		name_q.push_back(name);
		exp_q.push_back(expected);
		act_q.push_back(actual);
	endtask

	task automatic bus_write(input int page, input logic [3:0] off,
			input logic [`IO_DATA_BITS-1:0] data);
		address = addr_of(page, off);
		data_in = data;
		mem_wr  = 1'b1;
		model_write(page, off, data);
		@(negedge CLK);
		mem_wr = 1'b0;
	endtask

	// word shows on data_out through the next cycle
	task automatic bus_read(input int page, input logic [3:0] off,
			output logic [`IO_DATA_BITS-1:0] data);
		address = addr_of(page, off);
		mem_rd  = 1'b1;
		@(negedge CLK);
		data   = data_out;
		mem_rd = 1'b0;
	endtask

	task automatic read_check(input string name, input int page, input logic [3:0] off);
		logic [`IO_DATA_BITS-1:0] expected;
		logic [`IO_DATA_BITS-1:0] actual;
		expected = ref_read(page, off);
		bus_read(page, off, actual);
		expect_val(name, expected, actual);
	endtask

	task automatic poll_pending(input int bit_idx);
		logic [`IO_DATA_BITS-1:0] d;
		d = '0;
		while (d[bit_idx] !== 1'b1)
			bus_read(`IO_IRQ_PAGE, PENDING, d);
	endtask

	task automatic wait_irq(input logic level);
		while (interrupt !== level)
			@(negedge CLK);
	endtask

	always @(negedge CLK) begin
		while (act_q.size() > 0)
			check(name_q.pop_front(), exp_q.pop_front(), act_q.pop_front());
	end

	initial begin
		logic [`IO_DATA_BITS-1:0] d;
		logic [`IO_DATA_BITS-1:0] rl;
		int                       page;
		int                       k;
		int                       k2;
		void'($urandom(32'hc805_8c91));
		CLK     = 1'b0;
		RSTb    = 1'b0;
		address = '0;
		data_in = '0;
		mem_wr  = 1'b0;
		mem_rd  = 1'b0;
		cycles  = 0;
		for (int i = 0; i < `IO_NUM_TIMERS; i++) begin
			m_ctrl[i]   = '0;
			m_reload[i] = '0;
			m_count[i]  = '0;
		end
		m_pending = '0;
		m_mask    = '0;
		repeat (3) @(posedge CLK);
		@(negedge CLK);
		RSTb = 1'b1;

		for (int p = 0; p < 16; p++)
			for (int o = 0; o < 4; o++)
				read_check("reset value", p, 4'(o));
		expect_val("irq after reset", 16'h0, 16'(interrupt));

		// enable kept off so nothing counts yet
		for (int i = 0; i < 24; i++) begin
			page = i % 16;  // every page at least once, timer pages twice
			bus_write(page, RELOAD, 16'($urandom));
			bus_write(page, CTRL, 16'($urandom) & 16'hfffe);
			read_check("ctrl readback", page, CTRL);
			read_check("reload readback", page, RELOAD);
			read_check("count after reload", page, COUNT);
			read_check("unused offset", page, 4'($urandom_range(15, 3)));
		end

		k = $urandom_range(`IO_NUM_TIMERS - 1);
		bus_write(k, CTRL, 16'h0000);
		bus_write(k, RELOAD, 16'h1000 | 16'($urandom_range(4095)));
		repeat ($urandom_range(60, 10)) @(negedge CLK);
		read_check("disabled count holds", k, COUNT);

		// one-shot run down
		bus_write(`IO_IRQ_PAGE, MASK, 16'h0000);
		bus_write(k, RELOAD, 16'(3 + $urandom_range(5)));
		bus_write(k, CTRL, 16'h0001);
		poll_pending(k);
		m_ctrl[k]    = '0;
		m_count[k]   = '0;
		m_pending[k] = 1'b1;
		read_check("one-shot ctrl", k, CTRL);
		read_check("one-shot count", k, COUNT);
		read_check("one-shot pending", `IO_IRQ_PAGE, PENDING);

		repeat (8) begin
			@(negedge CLK);
			expect_val("irq masked off", 16'h0, 16'(interrupt));
		end
		bus_write(`IO_IRQ_PAGE, MASK, 16'(1 << k));
		wait_irq(1'b1);
		bus_write(`IO_IRQ_PAGE, PENDING, 16'(1 << k));
		wait_irq(1'b0);
		read_check("pending cleared", `IO_IRQ_PAGE, PENDING);
		read_check("mask readback", `IO_IRQ_PAGE, MASK);

		// reload mode on a neighbour channel
		k2 = (k + 1) % `IO_NUM_TIMERS;
		rl = 16'(20 + $urandom_range(20));
		bus_write(k2, RELOAD, rl);
		bus_write(k2, CTRL, 16'h0003);
		bus_read(k2, COUNT, d);
		expect_val("reload count range", 16'h1, 16'(d <= rl));
		repeat ($urandom_range(30, 5)) @(negedge CLK);
		bus_read(k2, COUNT, d);
		expect_val("reload count range", 16'h1, 16'(d <= rl));
		poll_pending(k2);
		bus_write(`IO_IRQ_PAGE, PENDING, 16'(1 << k2));
		bus_read(`IO_IRQ_PAGE, PENDING, d);
		expect_val("reload pending cleared", 16'h0, 16'(d[k2]));
		poll_pending(k2);  // next wrap sets it again

		repeat (2) @(negedge CLK);
		if (act_q.size() != 0) begin
			$display("Checks failed");
			$fatal(1, "compare queue still holds unchecked results");
		end else begin
			$display("All checks passed");
			$finish;
		end
	end

endmodule

`default_nettype wire
